// File: project.f
design/cpu_sm_pkg.sv
design/cpu_sm_terms.sv
design/cpu_sm_outputs.sv
design/cpu_sm_regs.sv
design/fifo_ptrs.sv
design/cpu_sm_top.sv
tb/cpu_sm_chk.sv
tb/cpu_sm_tb.sv

// File: Makefile
# Verilator build for the CPU bus master and its testbench

VERILATOR ?= verilator
TOP       ?= cpu_sm_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: tb/cpu_sm_tb.sv
// CPU bus master testbench: bus slave, grant model, reference lane checks, pointer tracking
`timescale 1ns/1ps

module cpu_sm_tb;
    import cpu_sm_pkg::*;

    // Longwords requested over all bursts
    localparam int PLANNED_LW  = 19;
    localparam int CYCLE_LIMIT = 40 * PLANNED_LW + 200;

    logic clk      = 1'b0;
    logic rst_n    = 1'b0;
    logic rdfifo_n = 1'b1;
    logic rififo_n = 1'b1;
    logic bgrant_n = 1'b1;
    logic dsack    = 1'b0;
    logic sterm_n  = 1'b1;
    logic flush    = 1'b0;
    cpu_bus_ctrl_t    bus;
    fifo_ctrl_t       fifo;
    logic [PTR_W-1:0] in_ptr;
    logic [PTR_W-1:0] out_ptr;

    logic [15:0] lfsr = 16'd48755;
    int cycles, checks, mismatches, failures, done_cnt, stop_cnt, rst_cycles;
    int wait_left, kind, gnt_delay, half;
    logic busy = 1'b0;
    logic cur_read = 1'b0;
    logic port16, last_breq, done, exp_incno, exp_incni, exp_stop;
    logic exp_strobe, addr_phase, more;
    logic [PTR_W-1:0] exp_in, exp_out;
    logic [4:0] lanes;

    cpu_sm_top dut0 (
        .clk(clk), .rst_n(rst_n), .rdfifo_n(rdfifo_n), .rififo_n(rififo_n),
        .bgrant_n(bgrant_n), .dsack(dsack), .sterm_n(sterm_n), .flush(flush),
        .bus(bus), .fifo(fifo), .in_ptr(in_ptr), .out_ptr(out_ptr)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Expected {size1, f2cpu_l, f2cpu_h, die_l, die_h} during a strobe
    function automatic logic [4:0] ref_lanes(input logic p16, input logic rd, input int hidx);
        logic [1:0] lh;
        logic s1;
        // First cycle offers both halves, a 16-bit port then takes the low half
        lh = (hidx == 0) ? 2'b11 : {p16, 1'b0};
        s1 = (hidx == 0) ? 1'b0 : p16;
        return rd ? {s1, 2'b00, lh} : {s1, lh, 2'b00};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        mismatches++;
    endtask

    // Bus slave, 0 to 3 wait cycles, then sterm_n or dsack
    always @(negedge clk) begin
        sterm_n = 1'b1;
        dsack = 1'b0;
        if (rst_n && bus.pds) begin
            if (!busy) begin
                draw_bits(2, wait_left);
                draw_bits(1, kind);
                busy = 1'b1;
            end
            if (wait_left == 0) begin
                if (kind != 0) dsack = 1'b1;
                else sterm_n = 1'b0;
                busy = 1'b0;
            end else begin
                wait_left--;
            end
        end else begin
            busy = 1'b0;
        end
    end

    // Arbiter grants two cycles after breq
    always @(negedge clk) begin
        if (!rst_n || (!bus.breq && !bus.bgack)) begin
            bgrant_n = 1'b1;
            gnt_delay = 2;
        end else if (bus.breq) begin
            if (gnt_delay == 0) bgrant_n = 1'b0;
            else gnt_delay--;
        end
    end

    // Compare process, sees the values registered at the previous edge
    always @(posedge clk) begin
        if (!rst_n) begin
            rst_cycles++;
            if (rst_cycles > 1 && (bus !== '0 || fifo !== '0 || in_ptr !== '0 || out_ptr !== '0))
                report_mismatch("reset outputs", 32'({bus, fifo, in_ptr, out_ptr}), 32'd0);
            {exp_incno, exp_incni, exp_stop, exp_strobe, addr_phase, port16, last_breq} = '0;
            exp_in = '0;
            exp_out = '0;
            half = 0;
        end else begin
            checks++;
            if (fifo.incno !== exp_incno) report_mismatch("incno", 32'(fifo.incno), 32'(exp_incno));
            if (fifo.incni !== exp_incni) report_mismatch("incni", 32'(fifo.incni), 32'(exp_incni));
            if (fifo.decfifo !== exp_incno)
                report_mismatch("decfifo", 32'(fifo.decfifo), 32'(exp_incno));
            if (fifo.incfifo !== exp_incni)
                report_mismatch("incfifo", 32'(fifo.incfifo), 32'(exp_incni));
            if (fifo.stopflush !== exp_stop)
                report_mismatch("stopflush", 32'(fifo.stopflush), 32'(exp_stop));
            if (bus.pas !== exp_strobe) report_mismatch("pas", 32'(bus.pas), 32'(exp_strobe));
            if (bus.pds !== exp_strobe) report_mismatch("pds", 32'(bus.pds), 32'(exp_strobe));
            if (out_ptr !== exp_out) report_mismatch("out_ptr", 32'(out_ptr), 32'(exp_out));
            if (in_ptr !== exp_in) report_mismatch("in_ptr", 32'(in_ptr), 32'(exp_in));
            if (last_breq && !bus.breq && !bus.bgack) begin
                $display("error: breq fell without bgack rising at %0t", $time);
                failures++;
            end
            lanes = bus.pds ? ref_lanes(port16, cur_read, half) : 5'b0;
            if ({bus.size1, bus.f2cpu_l, bus.f2cpu_h, bus.die_l, bus.die_h} !== lanes)
                report_mismatch("size1/lanes", 32'({bus.size1, bus.f2cpu_l, bus.f2cpu_h,
                                bus.die_l, bus.die_h}), 32'(lanes));
            if (fifo.stopflush) stop_cnt++;
            exp_out = exp_stop ? '0 : exp_out + PTR_W'(exp_incno);
            exp_in = exp_stop ? '0 : exp_in + PTR_W'(exp_incni);
            done = 1'b0;
            if (bus.pds && (!sterm_n || dsack)) begin
                if (half == 0 && sterm_n) begin
                    half = 1;
                    port16 = 1'b1;
                end else begin
                    done = 1'b1;
                    half = 0;
                    port16 = 1'b0;
                    done_cnt++;
                end
            end
            // Strobes follow an address cycle and hold until the longword ends
            more = cur_read ? !rififo_n : !rdfifo_n;
            exp_strobe = addr_phase || (bus.pds && !done);
            addr_phase = (bus.breq && !bgrant_n) || (done && more && !flush);
            exp_incno = done && !cur_read;
            exp_incni = done && cur_read;
            exp_stop = done && flush;
            last_breq = bus.breq;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("error: timeout, no return to idle within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // One burst; flush_at < 0 runs n longwords, else flush after flush_at of them
    task automatic run_burst(input logic wr, input logic rd, input int n, input int flush_at);
        int start;
        int stops;
        int expect_lw;
        logic [PTR_W-1:0] ptr0;
        logic [PTR_W-1:0] ptr_now;
        start = done_cnt;
        stops = stop_cnt;
        ptr0 = wr ? out_ptr : in_ptr;
        expect_lw = (flush_at >= 0) ? flush_at + 1 : n;
        cur_read = !wr;
        @(negedge clk);
        rdfifo_n = !wr;
        rififo_n = !rd;
        @(negedge clk);
        if (bus.breq !== 1'b1) report_mismatch("breq", 32'(bus.breq), 32'd1);
        while (bus.bgack !== 1'b1) @(negedge clk);
        while (bus.bgack === 1'b1) begin
            // Requests drop before the last longword ends
            if (done_cnt - start >= n - 1 || done_cnt - start == flush_at) begin
                rdfifo_n = 1'b1;
                rififo_n = 1'b1;
            end
            if (done_cnt - start == flush_at) flush = 1'b1;
            @(negedge clk);
        end
        flush = 1'b0;
        if (done_cnt - start != expect_lw) begin
            $display("error: bgack dropped after %0d longwords, %0d expected",
                     done_cnt - start, expect_lw);
            failures++;
        end
        ptr_now = wr ? out_ptr : in_ptr;
        if (flush_at >= 0) begin
            if (stop_cnt - stops != 1) begin
                $display("error: stopflush pulsed %0d times instead of once", stop_cnt - stops);
                failures++;
            end
            if ({in_ptr, out_ptr} !== '0)
                report_mismatch("in_ptr/out_ptr", 32'({in_ptr, out_ptr}), 32'd0);
        end else if (ptr_now !== PTR_W'(int'(ptr0) + n)) begin
            report_mismatch(wr ? "out_ptr" : "in_ptr", 32'(ptr_now), 32'(PTR_W'(int'(ptr0) + n)));
        end
    endtask

    initial begin
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        run_burst(1'b1, 1'b0, 6, -1);
        run_burst(1'b0, 1'b1, 6, -1);
        // Both requests pending, write goes first
        run_burst(1'b1, 1'b1, 2, -1);
        run_burst(1'b1, 1'b0, 5, 2);
        repeat (4) @(negedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, failures, dut0.regs0.chk0.fails);
        if (mismatches + failures + dut0.regs0.chk0.fails == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: tb/cpu_sm_chk.sv
// Bus protocol checker for the CPU bus master register stage
`timescale 1ns/1ps

module cpu_sm_chk (
    input logic                      clk,
    input logic                      rst_n,
    input cpu_sm_pkg::cpu_bus_ctrl_t bus,
    input cpu_sm_pkg::fifo_ctrl_t    fifo
);

    // Failed assertions so far, read by the testbench at the end
    int fails = 0;

    // Strobes only while the bus is owned
    a_pas_bgack: assert property (@(posedge clk) disable iff (!rst_n) bus.pas |-> bus.bgack)
        else begin
            $error("pas high without bgack");
            fails++;
        end

    a_pds_pas: assert property (@(posedge clk) disable iff (!rst_n) bus.pds |-> bus.pas)
        else begin
            $error("pds high without pas");
            fails++;
        end

    a_breq_bgack: assert property (@(posedge clk) disable iff (!rst_n) !(bus.breq && bus.bgack))
        else begin
            $error("breq and bgack high together");
            fails++;
        end

    // One-cycle pulse on flush completion
    a_stop_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                   fifo.stopflush |=> !fifo.stopflush)
        else begin
            $error("stopflush held longer than one cycle");
            fails++;
        end

endmodule

bind cpu_sm_regs cpu_sm_chk chk0 (.clk(clk), .rst_n(rst_n), .bus(bus), .fifo(fifo));

// File: design/cpu_sm_top.sv
// CPU bus master top: term decoder, output decoder, registers and FIFO pointers
`timescale 1ns/1ps

module cpu_sm_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rdfifo_n,
    input  logic                         rififo_n,
    input  logic                         bgrant_n,
    input  logic                         dsack,
    input  logic                         sterm_n,
    input  logic                         flush,
    output cpu_sm_pkg::cpu_bus_ctrl_t    bus,
    output cpu_sm_pkg::fifo_ctrl_t       fifo,
    output logic [cpu_sm_pkg::PTR_W-1:0] in_ptr,
    output logic [cpu_sm_pkg::PTR_W-1:0] out_ptr
);
    import cpu_sm_pkg::*;

    logic [N_TERMS-1:0] term;
    cpu_state_e         state;
    cpu_state_e         next_state;
    cpu_bus_ctrl_t      next_bus;
    fifo_ctrl_t         next_fifo;

    cpu_sm_terms terms0 (
        .state    (state),
        .rdfifo_n (rdfifo_n),
        .rififo_n (rififo_n),
        .bgrant_n (bgrant_n),
        .flush    (flush),
        .term     (term)
    );

    cpu_sm_outputs outputs0 (
        .term       (term),
        .dsack      (dsack),
        .sterm_n    (sterm_n),
        .next_state (next_state),
        .next_bus   (next_bus),
        .next_fifo  (next_fifo)
    );

    cpu_sm_regs regs0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .next_state (next_state),
        .next_bus   (next_bus),
        .next_fifo  (next_fifo),
        .state      (state),
        .bus        (bus),
        .fifo       (fifo)
    );

    fifo_ptrs ptrs0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .fifo    (fifo),
        .in_ptr  (in_ptr),
        .out_ptr (out_ptr)
    );

endmodule

// File: design/fifo_ptrs.sv
// FIFO longword pointers: in and out counters stepped by the bus master strobes
`timescale 1ns/1ps

module fifo_ptrs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cpu_sm_pkg::fifo_ctrl_t       fifo,
    output logic [cpu_sm_pkg::PTR_W-1:0] in_ptr,
    output logic [cpu_sm_pkg::PTR_W-1:0] out_ptr
);
    import cpu_sm_pkg::*;

    // In pointer, one step per longword read from memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ptr <= '0;
        end else if (fifo.stopflush) begin
            in_ptr <= '0;
        end else if (fifo.incni) begin
            in_ptr <= in_ptr + PTR_W'(1);
        end
    end

    // Out pointer, one step per longword written to memory
    // wraps at 16 like the in pointer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_ptr <= '0;
        end else if (fifo.stopflush) begin
            out_ptr <= '0;
        end else if (fifo.incno) begin
            out_ptr <= out_ptr + PTR_W'(1);
        end
    end

endmodule

// File: design/cpu_sm_regs.sv
// CPU bus master register stage: state and registered bus and FIFO controls
`timescale 1ns/1ps

module cpu_sm_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_sm_pkg::cpu_state_e    next_state,
    input  cpu_sm_pkg::cpu_bus_ctrl_t next_bus,
    input  cpu_sm_pkg::fifo_ctrl_t    next_fifo,
    output cpu_sm_pkg::cpu_state_e    state,
    output cpu_sm_pkg::cpu_bus_ctrl_t bus,
    output cpu_sm_pkg::fifo_ctrl_t    fifo
);
    import cpu_sm_pkg::*;

    // State register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Bus controls, registered so the strobes leave glitch free
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus <= '0;
        end else begin
            bus <= next_bus;
        end
    end

    // FIFO strobes, one-cycle pulses from the decoder
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fifo <= '0;
        end else begin
            fifo <= next_fifo;
        end
    end

endmodule

// File: design/cpu_sm_outputs.sv
// CPU bus master output decoder: terms and terminations into next state and controls
`timescale 1ns/1ps

module cpu_sm_outputs (
    input  logic [cpu_sm_pkg::N_TERMS-1:0] term,
    input  logic                           dsack,
    input  logic                           sterm_n,
    output cpu_sm_pkg::cpu_state_e         next_state,
    output cpu_sm_pkg::cpu_bus_ctrl_t      next_bus,
    output cpu_sm_pkg::fifo_ctrl_t         next_fifo
);
    import cpu_sm_pkg::*;

    localparam int SW = $bits(cpu_state_e);

    // Termination qualifiers
    logic term_full, term_16, no_term, any_term;

    // Partial sums per data state
    logic wr_data, wr_half2, rd_data, rd_half2;
    logic wr_more_done, wr_last_done, wr_flush_done;
    logic rd_more_done, rd_last_done, rd_flush_done;
    logic wr_done, rd_done;

    // One go signal per next state
    logic go_idle, go_req, go_gw;
    logic go_wr_addr, go_wr_data, go_wr_half2;
    logic go_rd_addr, go_rd_data, go_rd_half2;
    logic go_flush_end, go_release;
    logic strobe_sum;
    logic [SW-1:0] ns_bits;

    // sterm_n has priority over dsack
    assign term_full = ~sterm_n;
    assign term_16   = sterm_n & dsack;
    assign no_term   = sterm_n & ~dsack;
    assign any_term  = ~no_term;

    assign wr_data  = term[T_WRDATA_MORE] | term[T_WRDATA_LAST] | term[T_WRDATA_FLUSH];
    assign wr_half2 = term[T_WRHALF2_MORE] | term[T_WRHALF2_LAST] | term[T_WRHALF2_FLUSH];
    assign rd_data  = term[T_RDDATA_MORE] | term[T_RDDATA_LAST] | term[T_RDDATA_FLUSH];
    assign rd_half2 = term[T_RDHALF2_MORE] | term[T_RDHALF2_LAST] | term[T_RDHALF2_FLUSH];

    // A longword ends on a 32-bit term or on the second 16-bit term
    assign wr_more_done  = (term[T_WRDATA_MORE] & term_full)
                         | (term[T_WRHALF2_MORE] & any_term);
    assign wr_last_done  = (term[T_WRDATA_LAST] & term_full)
                         | (term[T_WRHALF2_LAST] & any_term);
    assign wr_flush_done = (term[T_WRDATA_FLUSH] & term_full)
                         | (term[T_WRHALF2_FLUSH] & any_term);
    assign rd_more_done  = (term[T_RDDATA_MORE] & term_full)
                         | (term[T_RDHALF2_MORE] & any_term);
    assign rd_last_done  = (term[T_RDDATA_LAST] & term_full)
                         | (term[T_RDHALF2_LAST] & any_term);
    assign rd_flush_done = (term[T_RDDATA_FLUSH] & term_full)
                         | (term[T_RDHALF2_FLUSH] & any_term);

    assign wr_done = wr_more_done | wr_last_done | wr_flush_done;
    assign rd_done = rd_more_done | rd_last_done | rd_flush_done;

    // Next-state sums
    assign go_idle      = term[T_IDLE_NOREQ] | term[T_RELEASE];
    assign go_req       = term[T_IDLE_REQ];
    assign go_gw        = term[T_REQ_NOGNT] | term[T_GW_NOGNT];
    assign go_wr_addr   = term[T_REQ_GNT_WR] | term[T_GW_GNT_WR] | wr_more_done;
    assign go_wr_data   = term[T_WRADDR] | (wr_data & no_term);
    assign go_wr_half2  = (wr_data & term_16) | (wr_half2 & no_term);
    assign go_rd_addr   = term[T_REQ_GNT_RD] | term[T_GW_GNT_RD] | rd_more_done;
    assign go_rd_data   = term[T_RDADDR] | (rd_data & no_term);
    assign go_rd_half2  = (rd_data & term_16) | (rd_half2 & no_term);
    assign go_flush_end = wr_flush_done | rd_flush_done;
    assign go_release   = wr_last_done | rd_last_done | term[T_FLUSH_END];

    assign ns_bits = ({SW{go_idle}} & ST_IDLE)
                   | ({SW{go_req}} & ST_REQ)
                   | ({SW{go_gw}} & ST_GRANT_WAIT)
                   | ({SW{go_wr_addr}} & ST_WR_ADDR)
                   | ({SW{go_wr_data}} & ST_WR_DATA)
                   | ({SW{go_wr_half2}} & ST_WR_HALF2)
                   | ({SW{go_rd_addr}} & ST_RD_ADDR)
                   | ({SW{go_rd_data}} & ST_RD_DATA)
                   | ({SW{go_rd_half2}} & ST_RD_HALF2)
                   | ({SW{go_flush_end}} & ST_FLUSH_END)
                   | ({SW{go_release}} & ST_RELEASE);

    assign next_state = cpu_state_e'(ns_bits);

    // Strobes are shared by pas and pds
    assign strobe_sum = go_wr_data | go_wr_half2 | go_rd_data | go_rd_half2;

    always_comb begin
        next_bus.breq  = go_req | go_gw;
        next_bus.bgack = go_wr_addr | go_wr_data | go_wr_half2
                       | go_rd_addr | go_rd_data | go_rd_half2
                       | go_flush_end | go_release;
        next_bus.pas   = strobe_sum;
        next_bus.pds   = strobe_sum;
        next_bus.size1 = go_wr_half2 | go_rd_half2;

        // Both halves first, low half alone on the second 16-bit cycle
        next_bus.f2cpu_h = go_wr_data;
        next_bus.f2cpu_l = go_wr_data | go_wr_half2;
        next_bus.die_h   = go_rd_data;
        next_bus.die_l   = go_rd_data | go_rd_half2;
    end

    always_comb begin
        next_fifo.incno     = wr_done;
        next_fifo.decfifo   = wr_done;
        next_fifo.incni     = rd_done;
        next_fifo.incfifo   = rd_done;
        next_fifo.stopflush = go_flush_end;
    end

endmodule

// File: design/cpu_sm_terms.sv
// CPU bus master term decoder: state and request inputs into a one-hot term vector
`timescale 1ns/1ps

module cpu_sm_terms (
    input  cpu_sm_pkg::cpu_state_e         state,
    input  logic                           rdfifo_n,
    input  logic                           rififo_n,
    input  logic                           bgrant_n,
    input  logic                           flush,
    output logic [cpu_sm_pkg::N_TERMS-1:0] term
);
    import cpu_sm_pkg::*;

    // State decodes, each used once per branch
    logic s_idle, s_req, s_gw;
    logic s_wr_addr, s_wr_data, s_wr_half2;
    logic s_rd_addr, s_rd_data, s_rd_half2;
    logic s_flush_end, s_release;

    // Branch conditions
    logic any_req, granted, wr_more, wr_last, rd_more, rd_last;

    assign s_idle      = (state == ST_IDLE);
    assign s_req       = (state == ST_REQ);
    assign s_gw        = (state == ST_GRANT_WAIT);
    assign s_wr_addr   = (state == ST_WR_ADDR);
    assign s_wr_data   = (state == ST_WR_DATA);
    assign s_wr_half2  = (state == ST_WR_HALF2);
    assign s_rd_addr   = (state == ST_RD_ADDR);
    assign s_rd_data   = (state == ST_RD_DATA);
    assign s_rd_half2  = (state == ST_RD_HALF2);
    assign s_flush_end = (state == ST_FLUSH_END);
    assign s_release   = (state == ST_RELEASE);

    assign any_req = ~rdfifo_n | ~rififo_n;
    assign granted = ~bgrant_n;

    // Flush overrides the burst continuation
    assign wr_more = ~flush & ~rdfifo_n;
    assign wr_last = ~flush & rdfifo_n;
    assign rd_more = ~flush & ~rififo_n;
    assign rd_last = ~flush & rififo_n;

    always_comb begin
        term = '0;

        term[T_IDLE_REQ]   = s_idle & any_req;
        term[T_IDLE_NOREQ] = s_idle & ~any_req;

        // Write wins the grant when both requests are pending
        term[T_REQ_NOGNT]  = s_req & ~granted;
        term[T_REQ_GNT_WR] = s_req & granted & ~rdfifo_n;
        term[T_REQ_GNT_RD] = s_req & granted & rdfifo_n;
        term[T_GW_NOGNT]   = s_gw & ~granted;
        term[T_GW_GNT_WR]  = s_gw & granted & ~rdfifo_n;
        term[T_GW_GNT_RD]  = s_gw & granted & rdfifo_n;

        term[T_WRADDR]        = s_wr_addr;
        term[T_WRDATA_MORE]   = s_wr_data & wr_more;
        term[T_WRDATA_LAST]   = s_wr_data & wr_last;
        term[T_WRDATA_FLUSH]  = s_wr_data & flush;
        term[T_WRHALF2_MORE]  = s_wr_half2 & wr_more;
        term[T_WRHALF2_LAST]  = s_wr_half2 & wr_last;
        term[T_WRHALF2_FLUSH] = s_wr_half2 & flush;

        term[T_RDADDR]        = s_rd_addr;
        term[T_RDDATA_MORE]   = s_rd_data & rd_more;
        term[T_RDDATA_LAST]   = s_rd_data & rd_last;
        term[T_RDDATA_FLUSH]  = s_rd_data & flush;
        term[T_RDHALF2_MORE]  = s_rd_half2 & rd_more;
        term[T_RDHALF2_LAST]  = s_rd_half2 & rd_last;
        term[T_RDHALF2_FLUSH] = s_rd_half2 & flush;

        term[T_FLUSH_END] = s_flush_end;
        term[T_RELEASE]   = s_release;
    end

endmodule

// File: design/cpu_sm_pkg.sv
// CPU bus master package: state and term encodings, control bundles, widths
package cpu_sm_pkg;

    // Width of the FIFO longword pointers
    localparam int PTR_W = 4;

    // One term per state and branch condition
    localparam int N_TERMS = 24;

    typedef enum logic [4:0] {
        ST_IDLE       = 5'd0,
        ST_REQ        = 5'd1,   // bus requested
        ST_GRANT_WAIT = 5'd2,
        ST_WR_ADDR    = 5'd3,
        ST_WR_DATA    = 5'd4,
        ST_WR_HALF2   = 5'd5,   // low word to a 16-bit port
        ST_RD_ADDR    = 5'd6,
        ST_RD_DATA    = 5'd7,
        ST_RD_HALF2   = 5'd8,
        ST_FLUSH_END  = 5'd9,
        ST_RELEASE    = 5'd10
    } cpu_state_e;

    typedef enum logic [4:0] {
        T_IDLE_REQ, T_IDLE_NOREQ,
        T_REQ_NOGNT, T_REQ_GNT_WR, T_REQ_GNT_RD,
        T_GW_NOGNT, T_GW_GNT_WR, T_GW_GNT_RD,
        T_WRADDR,
        T_WRDATA_MORE, T_WRDATA_LAST, T_WRDATA_FLUSH,
        T_WRHALF2_MORE, T_WRHALF2_LAST, T_WRHALF2_FLUSH,
        T_RDADDR,
        T_RDDATA_MORE, T_RDDATA_LAST, T_RDDATA_FLUSH,
        T_RDHALF2_MORE, T_RDHALF2_LAST, T_RDHALF2_FLUSH,
        T_FLUSH_END,
        T_RELEASE
    } sm_term_e;

    typedef struct packed {
        logic breq;
        logic bgack;
        logic pas;
        logic pds;
        logic size1;
        logic f2cpu_l;
        logic f2cpu_h;
        logic die_l;
        logic die_h;
    } cpu_bus_ctrl_t;

    typedef struct packed {
        logic incfifo;
        logic decfifo;
        logic incni;
        logic incno;
        logic stopflush;
    } fifo_ctrl_t;

endpackage
